// File: Makefile
# Verilator build and run of the ID stage testbench, invoke from the project root
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation PASSED" || \
		(echo "Simulation FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
src/id_pkg.sv
src/id_decoder.sv
src/id_operand_fwd.sv
src/id_operand_sel.sv
src/id_ex_reg.sv
src/id_stage.sv
sim/tb_clk_gen.sv
sim/id_stage_asserts.sv
sim/id_stage_tb.sv

// File: sim/id_patterns.txt
// instr pc in(v,rdy,kill,rnd) rf0 rf1 ex_ctl(ld,we,addr) ex_data wb_ctl wb_data
// out(rdy,jmp) jmp_tgt idex(addr[20:16] aluop[11:8] ill[4] br,lsu,we,v[3:0]) op_a op_b op_c
ffb10093 100 3 10 0 0 0 0 0 1 0 10003 10 fffffffb 0
002081b3 104 3 111 222 21 b 22 55 1 0 30003 b 55 55
40318233 108 3 333 333 23 e1 23 bb 1 0 40103 e1 e1 e1
004062b3 10c 3 999 444 20 dead 24 44 1 0 50803 0 44 44
12345337 110 3 0 0 0 0 0 0 1 0 60003 0 12345000 0
00001397 114 3 0 0 0 0 0 0 1 0 70003 114 1000 0
0050a623 118 3 1000 5555 0 0 0 0 1 0 c0005 1000 c 5555
0040a403 11c 3 2000 0 0 0 0 0 1 0 80007 2000 4 0
002404b3 120 3 888 22 68 0 0 0 0 0 0 0 0 0
002404b3 120 3 888 22 0 0 28 88 1 0 90003 88 22 22
0ff4c513 124 1 99 0 0 0 0 0 0 0 90003 88 22 22
0ff4c513 124 3 99 0 0 0 0 0 1 0 a0503 99 ff 0
020000ef 128 7 0 0 0 0 0 0 1 0 0 0 0 0
020000ef 128 3 0 0 0 0 0 0 3 148 10003 128 4 0
00328067 148 3 555 0 25 300 0 0 3 302 3 148 4 0
fe209ce3 300 3 11 12 0 0 0 0 1 0 190b09 11 12 2f8
00000073 304 3 77 77 0 0 0 0 1 0 11 0 0 0
00000000 308 a 0 0 0 0 0 0 1 0 0 0 0 0
7ff00593 30c b 0 0 0 0 0 0 1 0 0 0 0 0
7ff00593 310 3 abc 0 0 0 0 0 1 0 b0003 0 7ff 0

// File: sim/id_stage_asserts.sv
// Handshake and reset properties of the ID stage, bound into id_stage by the testbench
`timescale 1ns/1ps

module id_stage_asserts (
  input logic           clk,
  input logic           rst_n,
  input logic           ex_ready_i,
  input id_pkg::id_ex_t id_ex_i,
  input logic           id_ready_i,
  input logic           jmp_taken_i
);

  //////////////////////////////////////////////////
  // Back-pressure
  //////////////////////////////////////////////////
  // EX not taking anything, register must not move
  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_ready_i |=> $stable(id_ex_i))
    else $error("id_ex_o changed while ex_ready_i was low");

  // A redirect only ever comes from a jump that fires into EX
  jump_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
    jmp_taken_i |=> $past(id_ready_i) && id_ex_i.instr_valid)
    else $error("jmp_taken_o high without the jump entering id_ex_o");

  //////////////////////////////////////////////////
  // Reset
  //////////////////////////////////////////////////
  empty_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !id_ex_i.instr_valid)
    else $error("id_ex_o.instr_valid set in the first cycle after reset");

endmodule

// File: sim/id_stage_tb.sv
// Pattern driven testbench for the ID stage, run from the project root
`timescale 1ns/1ps

module id_stage_tb;
  import id_pkg::*;

  localparam int          PERIOD   = 100;
  localparam int          NUM_PAT  = 20;
  localparam int          NUM_COLS = 15;
  localparam logic [31:0] SEED     = 32'hb74b_021a;
  localparam string       PAT_FILE = "sim/id_patterns.txt";

  logic                                clk;
  logic                                rst_n;
  if_id_t                              if_id;
  fwd_src_t                            ex_fwd;
  fwd_src_t                            wb_fwd;
  logic                                ex_ready;
  logic                                kill;
  logic [NUM_READ_PORTS-1:0][XLEN-1:0] rf_rdata;
  logic [NUM_READ_PORTS-1:0][REG_ADDR_W-1:0] rf_raddr;
  logic [NUM_READ_PORTS-1:0]           rf_re;
  id_ex_t                              id_ex;
  logic                                id_ready;
  logic                                jmp_taken;
  logic [XLEN-1:0]                     jmp_target;

  // One word per column, NUM_COLS words per pattern line
  logic [31:0] pat_mem [NUM_PAT*NUM_COLS];
  int          err_count;
  int          cur_pat;
  int          fd;

  tb_clk_gen #(.PERIOD(PERIOD), .RESET_CYCLES(3)) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  id_stage UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_id_i      (if_id),
    .ex_fwd_i     (ex_fwd),
    .wb_fwd_i     (wb_fwd),
    .ex_ready_i   (ex_ready),
    .kill_i       (kill),
    .rf_rdata_i   (rf_rdata),
    .rf_raddr_o   (rf_raddr),
    .rf_re_o      (rf_re),
    .id_ex_o      (id_ex),
    .id_ready_o   (id_ready),
    .jmp_taken_o  (jmp_taken),
    .jmp_target_o (jmp_target)
  );

  bind id_stage id_stage_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_ready_i  (ex_ready_i),
    .id_ex_i     (id_ex_o),
    .id_ready_i  (id_ready_o),
    .jmp_taken_i (jmp_taken_o)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] col(input int idx, input int c);
    return pat_mem[idx*NUM_COLS + c];
  endfunction

  // Which of rs1 (bit 0) and rs2 (bit 1) each RV32I format reads
  function automatic logic [1:0] expected_read_enables(input logic [6:0] opcode);
    case (opcode)
      OPC_OP, OPC_BRANCH, OPC_STORE: return 2'b11;
      OPC_OPIMM, OPC_JALR, OPC_LOAD: return 2'b01;
      default:                       return 2'b00;
    endcase
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "Stopping at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      err_count++;
      abort_run($sformatf("** Error: pattern %0d %s = %h, expected %h",
                          cur_pat, name, actual, expected));
    end
  endtask

  // Flags: bit 0 valid, 1 ex_ready, 2 kill, 3 random register data
  task automatic apply_pattern(input int idx);
    logic [31:0] flags;
    logic [31:0] ex_ctl;
    logic [31:0] wb_ctl;
    flags             = col(idx, 2);
    ex_ctl            = col(idx, 5);
    wb_ctl            = col(idx, 7);
    if_id.instr       = col(idx, 0);
    if_id.pc          = col(idx, 1);
    if_id.instr_valid = flags[0];
    ex_ready          = flags[1];
    kill              = flags[2];
    if (flags[3]) begin
      rf_rdata[0] = $urandom;
      rf_rdata[1] = $urandom;
    end else begin
      rf_rdata[0] = col(idx, 3);
      rf_rdata[1] = col(idx, 4);
    end
    // Forward controls: addr in [4:0], we in [5], is_load in [6]
    ex_fwd.waddr   = ex_ctl[4:0];
    ex_fwd.we      = ex_ctl[5];
    ex_fwd.is_load = ex_ctl[6];
    ex_fwd.wdata   = col(idx, 6);
    wb_fwd.waddr   = wb_ctl[4:0];
    wb_fwd.we      = wb_ctl[5];
    wb_fwd.is_load = 1'b0;
    wb_fwd.wdata   = col(idx, 8);
  endtask

  task automatic check_pattern(input int idx);
    logic [31:0] flags;
    logic [31:0] out_flags;
    logic [31:0] exp_ctl;
    logic [31:0] instr;
    logic [1:0]  exp_re;
    flags     = col(idx, 2);
    out_flags = col(idx, 9);
    exp_ctl   = col(idx, 11);
    instr     = col(idx, 0);
    exp_re    = expected_read_enables(instr[6:0]);
    check_value("id_ready_o", 32'(id_ready), 32'(out_flags[0]));
    // Random register data, only the handshake is predictable
    if (!flags[3]) begin
      // Register file request, rs1 on port 0 and rs2 on port 1
      check_value("rf_re_o", 32'(rf_re), 32'(exp_re));
      if (exp_re[0]) begin
        check_value("rf_raddr_o[0]", 32'(rf_raddr[0]), 32'(instr[19:15]));
      end
      if (exp_re[1]) begin
        check_value("rf_raddr_o[1]", 32'(rf_raddr[1]), 32'(instr[24:20]));
      end
      check_value("jmp_taken_o", 32'(jmp_taken), 32'(out_flags[1]));
      if (out_flags[1]) begin
        check_value("jmp_target_o", jmp_target, col(idx, 10));
      end
      check_value("id_ex_o.instr_valid", 32'(id_ex.instr_valid), 32'(exp_ctl[0]));
      // Bubble leaves stale data behind the cleared valid
      if (exp_ctl[0]) begin
        check_value("id_ex_o.rf_we", 32'(id_ex.rf_we), 32'(exp_ctl[1]));
        check_value("id_ex_o.lsu_en", 32'(id_ex.lsu_en), 32'(exp_ctl[2]));
        check_value("id_ex_o.branch_in_ex", 32'(id_ex.branch_in_ex), 32'(exp_ctl[3]));
        check_value("id_ex_o.illegal_insn", 32'(id_ex.illegal_insn), 32'(exp_ctl[4]));
        check_value("id_ex_o.alu_op", 32'(id_ex.alu_op), 32'(exp_ctl[11:8]));
        check_value("id_ex_o.rf_waddr", 32'(id_ex.rf_waddr), 32'(exp_ctl[20:16]));
        check_value("id_ex_o.operand_a", id_ex.operand_a, col(idx, 12));
        check_value("id_ex_o.operand_b", id_ex.operand_b, col(idx, 13));
        check_value("id_ex_o.operand_c", id_ex.operand_c, col(idx, 14));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus and checking
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    err_count = 0;
    cur_pat   = 0;
    if_id     = '0;
    ex_fwd    = '0;
    wb_fwd    = '0;
    ex_ready  = 1'b0;
    kill      = 1'b0;
    rf_rdata  = '0;
    fd = $fopen(PAT_FILE, "r");
    if (fd == 0) begin
      abort_run("Cannot open the pattern file sim/id_patterns.txt");
    end
    $fclose(fd);
    $readmemh(PAT_FILE, pat_mem);

    wait (rst_n);
    @(posedge clk);
    for (int i = 0; i < NUM_PAT; i++) begin
      // Drive on the falling edge, sample just before the next one
      @(negedge clk);
      cur_pat = i;
      apply_pattern(i);
      @(posedge clk);
      #(PERIOD / 2 - 1);
      check_pattern(i);
    end

    if (err_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      abort_run("Checks failed during the run");
    end
  end

  // Watchdog, patterns plus reset and margin
  initial begin
    #((NUM_PAT + 10) * PERIOD);
    abort_run($sformatf("Timeout, run still going after %0d cycles", NUM_PAT + 10));
  end

endmodule

// File: sim/tb_clk_gen.sv
// Testbench clock and power-on reset source, instanced once by the ID stage testbench
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free running, first rising edge at half a period
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Released on a falling edge, clear of the rising edges
  initial begin
    rst_n_o = 1'b0;
    #(PERIOD * RESET_CYCLES) rst_n_o = 1'b1;
  end

endmodule

// File: src/id_decoder.sv
// RV32I base decoder, turns one instruction word into the ID control bundle
`timescale 1ns/1ps

module id_decoder (
  input  id_pkg::instr_u                                             instr_i,
  output id_pkg::dec_ctrl_t                                          ctrl_o,
  output logic [id_pkg::NUM_READ_PORTS-1:0][id_pkg::REG_ADDR_W-1:0] raddr_o,
  output logic [id_pkg::NUM_READ_PORTS-1:0]                         re_o,
  output logic [id_pkg::REG_ADDR_W-1:0]                             waddr_o
);
  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // funct3 map shared by OP and OP-IMM
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  endfunction

  assign opcode = instr_i.r_fmt.opcode;
  assign funct3 = instr_i.r_fmt.funct3;
  assign funct7 = instr_i.r_fmt.funct7;

  // Fixed field positions, rs1 on port 0 and rs2 on port 1
  assign raddr_o[0] = instr_i.r_fmt.rs1;
  assign raddr_o[1] = instr_i.r_fmt.rs2;
  assign waddr_o    = instr_i.r_fmt.rd;

  always_comb begin
    // All-zero bundle: ADD, REG, REG, I-type, nothing enabled
    ctrl_o = '0;
    re_o   = '0;
    case (opcode)
      OPC_OP: begin
        ctrl_o.alu_en = 1'b1;
        ctrl_o.rf_we  = 1'b1;
        re_o          = '1;
        ctrl_o.alu_op = arith_op(funct3, funct7[5]);
        // Alternate funct7 only for SUB and SRA
        if (funct7 != 7'h00 &&
            !(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          ctrl_o.illegal = 1'b1;
        end
      end
      OPC_OPIMM: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_b_sel = OP_B_IMM;
        re_o[0]         = 1'b1;
        ctrl_o.alu_op   = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
        // Shifts reuse the upper immediate bits as funct7
        if (funct3 == 3'b001 && funct7 != 7'h00) begin
          ctrl_o.illegal = 1'b1;
        end
        if (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20) begin
          ctrl_o.illegal = 1'b1;
        end
      end
      OPC_LUI, OPC_AUIPC: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = IMM_U;
      end
      OPC_JAL, OPC_JALR: begin
        // ALU forms the link address pc + 4
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_PCINCR;
        ctrl_o.is_jal   = (opcode == OPC_JAL);
        ctrl_o.is_jalr  = (opcode == OPC_JALR);
        ctrl_o.imm_sel  = (opcode == OPC_JAL) ? IMM_J : IMM_I;
        re_o[0]         = (opcode == OPC_JALR);
        ctrl_o.illegal  = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl_o.alu_en    = 1'b1;
        ctrl_o.is_branch = 1'b1;
        ctrl_o.imm_sel   = IMM_B;
        re_o             = '1;
        case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_EQ;
          3'b001:  ctrl_o.alu_op = ALU_NE;
          3'b100:  ctrl_o.alu_op = ALU_LT;
          3'b101:  ctrl_o.alu_op = ALU_GE;
          3'b110:  ctrl_o.alu_op = ALU_LTU;
          3'b111:  ctrl_o.alu_op = ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      OPC_LOAD, OPC_STORE: begin
        // Address is rs1 + I or S immediate
        ctrl_o.alu_en       = 1'b1;
        ctrl_o.lsu_en       = 1'b1;
        ctrl_o.op_b_sel     = OP_B_IMM;
        ctrl_o.lsu_type     = funct3[1:0];
        re_o[0]             = 1'b1;
        ctrl_o.illegal      = (funct3[1:0] == 2'b11);
        if (opcode == OPC_LOAD) begin
          ctrl_o.rf_we        = 1'b1;
          ctrl_o.lsu_sign_ext = !funct3[2];
          if (funct3 == 3'b110) begin
            ctrl_o.illegal = 1'b1;
          end
        end else begin
          ctrl_o.lsu_we  = 1'b1;
          ctrl_o.imm_sel = IMM_S;
          re_o[1]        = 1'b1;
          if (funct3[2]) begin
            ctrl_o.illegal = 1'b1;
          end
        end
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal words must not write, access memory or redirect
    if (ctrl_o.illegal) begin
      ctrl_o.alu_en    = 1'b0;
      ctrl_o.rf_we     = 1'b0;
      ctrl_o.lsu_en    = 1'b0;
      ctrl_o.lsu_we    = 1'b0;
      ctrl_o.is_branch = 1'b0;
      ctrl_o.is_jal    = 1'b0;
      ctrl_o.is_jalr   = 1'b0;
    end
  end

endmodule

// File: src/id_ex_reg.sv
// ID/EX pipeline register with stage ready, bubble insertion and hold on back-pressure
`timescale 1ns/1ps

module id_ex_reg (
  input  logic                                clk,
  input  logic                                rst_n,
  input  id_pkg::if_id_t                      if_id_i,
  input  id_pkg::dec_ctrl_t                   ctrl_i,
  input  logic [id_pkg::REG_ADDR_W-1:0]       waddr_i,
  input  logic [id_pkg::XLEN-1:0]             operand_a_i,
  input  logic [id_pkg::XLEN-1:0]             operand_b_i,
  input  logic [id_pkg::XLEN-1:0]             operand_c_i,
  input  logic [id_pkg::NUM_READ_PORTS-1:0]   hazard_i,
  input  logic                                ex_ready_i,
  input  logic                                kill_i,
  output id_pkg::id_ex_t                      id_ex_o,
  output logic                                id_ready_o,
  output logic                                jmp_taken_o
);
  import id_pkg::*;

  logic   fire;
  id_ex_t id_ex_d;

  // Kill always drains the stage, otherwise wait on EX and any hazard
  assign id_ready_o  = kill_i || (ex_ready_i && !(|hazard_i));
  assign fire        = if_id_i.instr_valid && !kill_i && id_ready_o;
  assign jmp_taken_o = fire && (ctrl_i.is_jal || ctrl_i.is_jalr);

  // Next contents when the stage fires
  always_comb begin
    id_ex_d.instr_valid  = 1'b1;
    id_ex_d.pc           = if_id_i.pc;
    id_ex_d.alu_en       = ctrl_i.alu_en;
    id_ex_d.alu_op       = ctrl_i.alu_op;
    id_ex_d.operand_a    = operand_a_i;
    id_ex_d.operand_b    = operand_b_i;
    id_ex_d.operand_c    = operand_c_i;
    id_ex_d.rf_we        = ctrl_i.rf_we;
    id_ex_d.rf_waddr     = waddr_i;
    id_ex_d.lsu_en       = ctrl_i.lsu_en;
    id_ex_d.lsu_we       = ctrl_i.lsu_we;
    id_ex_d.lsu_type     = ctrl_i.lsu_type;
    id_ex_d.lsu_sign_ext = ctrl_i.lsu_sign_ext;
    id_ex_d.branch_in_ex = ctrl_i.is_branch;
    id_ex_d.illegal_insn = ctrl_i.illegal;
  end

  //////////////////////////////////////////////////
  // Load, bubble or hold
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_o <= '0;
    end else if (fire) begin
      id_ex_o <= id_ex_d;
    end else if (ex_ready_i) begin
      // EX takes the old one, nothing new behind it
      id_ex_o.instr_valid <= 1'b0;
    end
  end

endmodule

// File: src/id_operand_fwd.sv
// One register read port: EX/WB bypass, x0 zeroing and load-use hazard check
`timescale 1ns/1ps

module id_operand_fwd (
  input  logic [id_pkg::REG_ADDR_W-1:0] raddr_i,
  input  logic                          re_i,
  input  logic [id_pkg::XLEN-1:0]       rf_rdata_i,
  input  id_pkg::fwd_src_t              ex_fwd_i,
  input  id_pkg::fwd_src_t              wb_fwd_i,
  output logic [id_pkg::XLEN-1:0]       operand_o,
  output logic                          hazard_o
);
  import id_pkg::*;

  logic            active;
  logic            ex_match;
  logic            wb_match;
  logic [XLEN-1:0] fwd_val;

  // x0 never matches, so it never forwards or stalls
  assign active   = re_i && (raddr_i != '0);
  assign ex_match = active && ex_fwd_i.we && (ex_fwd_i.waddr == raddr_i);
  assign wb_match = active && wb_fwd_i.we && (wb_fwd_i.waddr == raddr_i);

  // Youngest result wins
  always_comb begin
    if (ex_match && !ex_fwd_i.is_load) begin
      fwd_val = ex_fwd_i.wdata;
    end else if (wb_match) begin
      fwd_val = wb_fwd_i.wdata;
    end else begin
      fwd_val = rf_rdata_i;
    end
  end

  assign operand_o = (raddr_i == '0) ? '0 : fwd_val;
  // Load data not back until WB
  assign hazard_o  = ex_match && ex_fwd_i.is_load;

endmodule

// File: src/id_operand_sel.sv
// Immediate extraction and operand A/B/C muxing, plus the JAL/JALR target adder
`timescale 1ns/1ps

module id_operand_sel (
  input  id_pkg::instr_u          instr_i,
  input  logic [id_pkg::XLEN-1:0] pc_i,
  input  id_pkg::dec_ctrl_t       ctrl_i,
  input  logic [id_pkg::XLEN-1:0] rs1_i,
  input  logic [id_pkg::XLEN-1:0] rs2_i,
  output logic [id_pkg::XLEN-1:0] operand_a_o,
  output logic [id_pkg::XLEN-1:0] operand_b_o,
  output logic [id_pkg::XLEN-1:0] operand_c_o,
  output logic [id_pkg::XLEN-1:0] jmp_target_o
);
  import id_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] jalr_sum;

  //////////////////////////////////////////////////
  // Sign-extended immediates
  //////////////////////////////////////////////////
  assign imm_i = {{20{instr_i.i_fmt.imm12[11]}}, instr_i.i_fmt.imm12};
  assign imm_s = {{20{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
  // B-type through the S view, bit 11 lives in imm_lo[0]
  assign imm_b = {{20{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_lo[0],
                  instr_i.s_fmt.imm_hi[5:0], instr_i.s_fmt.imm_lo[4:1], 1'b0};
  assign imm_u = {instr_i.u_fmt.imm20, 12'b0};
  // J-type through the U view
  assign imm_j = {{12{instr_i.u_fmt.imm20[19]}}, instr_i.u_fmt.imm20[7:0],
                  instr_i.u_fmt.imm20[8], instr_i.u_fmt.imm20[18:9], 1'b0};

  always_comb begin
    case (ctrl_i.imm_sel)
      IMM_S:   imm = imm_s;
      IMM_B:   imm = imm_b;
      IMM_U:   imm = imm_u;
      IMM_J:   imm = imm_j;
      default: imm = imm_i;
    endcase
  end

  //////////////////////////////////////////////////
  // Operand muxes
  //////////////////////////////////////////////////
  always_comb begin
    case (ctrl_i.op_a_sel)
      OP_A_PC:   operand_a_o = pc_i;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = rs1_i;
    endcase
  end

  always_comb begin
    case (ctrl_i.op_b_sel)
      OP_B_IMM:    operand_b_o = imm;
      OP_B_PCINCR: operand_b_o = PC_INCR;
      default:     operand_b_o = rs2_i;
    endcase
  end

  // Branch target for EX, otherwise store data
  assign operand_c_o = ctrl_i.is_branch ? (pc_i + imm_b) : rs2_i;

  // JALR clears the LSB of rs1 + imm
  assign jalr_sum     = rs1_i + imm_i;
  assign jmp_target_o = ctrl_i.is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : (pc_i + imm_j);

endmodule

// File: src/id_pkg.sv
// Shared widths, opcodes, encodings and pipeline bundles for the ID stage modules
package id_pkg;

  //////////////////////////////////////////////////
  // Widths and constants
  //////////////////////////////////////////////////
  localparam int XLEN           = 32;
  localparam int REG_ADDR_W     = 5;
  localparam int NUM_READ_PORTS = 2;
  // Return address step, no compressed instructions
  localparam logic [XLEN-1:0] PC_INCR = 32'd4;

  // RV32I major opcodes kept by this decoder
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OPIMM  = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;

  //////////////////////////////////////////////////
  // Control encodings
  //////////////////////////////////////////////////
  // Arithmetic ops first, branch compares in the top half
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
    ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_PCINCR} op_b_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

  //////////////////////////////////////////////////
  // Instruction word views
  //////////////////////////////////////////////////
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    // Also the B-type layout, bits reshuffled
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
    // Also the J-type layout, bits reshuffled
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
  } instr_u;

  //////////////////////////////////////////////////
  // Pipeline bundles
  //////////////////////////////////////////////////
  typedef struct packed {
    logic            instr_valid;
    logic [XLEN-1:0] pc;
    instr_u          instr;
  } if_id_t;

  // Result from EX or WB, is_load only meaningful from EX
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
    logic                  is_load;
  } fwd_src_t;

  typedef struct packed {
    logic      alu_en;
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    imm_sel_e  imm_sel;
    logic      rf_we;
    logic      lsu_en;
    logic      lsu_we;
    logic [1:0] lsu_type;
    logic      lsu_sign_ext;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      illegal;
  } dec_ctrl_t;

  typedef struct packed {
    logic                  instr_valid;
    logic [XLEN-1:0]       pc;
    logic                  alu_en;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    // Store data or branch target
    logic [XLEN-1:0]       operand_c;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic                  lsu_en;
    logic                  lsu_we;
    logic [1:0]            lsu_type;
    logic                  lsu_sign_ext;
    logic                  branch_in_ex;
    logic                  illegal_insn;
  } id_ex_t;

endpackage

// File: src/id_stage.sv
// ID stage top, wires the decoder, per-port forwarding, operand muxes and ID/EX register
`timescale 1ns/1ps

module id_stage (
  input  logic                                                       clk,
  input  logic                                                       rst_n,
  input  id_pkg::if_id_t                                             if_id_i,
  input  id_pkg::fwd_src_t                                           ex_fwd_i,
  input  id_pkg::fwd_src_t                                           wb_fwd_i,
  input  logic                                                       ex_ready_i,
  input  logic                                                       kill_i,
  input  logic [id_pkg::NUM_READ_PORTS-1:0][id_pkg::XLEN-1:0]       rf_rdata_i,
  output logic [id_pkg::NUM_READ_PORTS-1:0][id_pkg::REG_ADDR_W-1:0] rf_raddr_o,
  output logic [id_pkg::NUM_READ_PORTS-1:0]                         rf_re_o,
  output id_pkg::id_ex_t                                             id_ex_o,
  output logic                                                       id_ready_o,
  output logic                                                       jmp_taken_o,
  output logic [id_pkg::XLEN-1:0]                                    jmp_target_o
);
  import id_pkg::*;

  dec_ctrl_t                           ctrl;
  logic [REG_ADDR_W-1:0]               waddr;
  logic [NUM_READ_PORTS-1:0][XLEN-1:0] operand_fw;
  logic [NUM_READ_PORTS-1:0]           hazard;
  logic [XLEN-1:0]                     operand_a;
  logic [XLEN-1:0]                     operand_b;
  logic [XLEN-1:0]                     operand_c;

  id_decoder u_decoder (
    .instr_i (if_id_i.instr),
    .ctrl_o  (ctrl),
    .raddr_o (rf_raddr_o),
    .re_o    (rf_re_o),
    .waddr_o (waddr)
  );

  // Port 0 is rs1, port 1 is rs2
  for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_fwd
    id_operand_fwd u_fwd (
      .raddr_i    (rf_raddr_o[p]),
      .re_i       (rf_re_o[p]),
      .rf_rdata_i (rf_rdata_i[p]),
      .ex_fwd_i   (ex_fwd_i),
      .wb_fwd_i   (wb_fwd_i),
      .operand_o  (operand_fw[p]),
      .hazard_o   (hazard[p])
    );
  end

  id_operand_sel u_operand_sel (
    .instr_i      (if_id_i.instr),
    .pc_i         (if_id_i.pc),
    .ctrl_i       (ctrl),
    .rs1_i        (operand_fw[0]),
    .rs2_i        (operand_fw[1]),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b),
    .operand_c_o  (operand_c),
    .jmp_target_o (jmp_target_o)
  );

  id_ex_reg u_id_ex_reg (
    .clk         (clk),
    .rst_n       (rst_n),
    .if_id_i     (if_id_i),
    .ctrl_i      (ctrl),
    .waddr_i     (waddr),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .operand_c_i (operand_c),
    .hazard_i    (hazard),
    .ex_ready_i  (ex_ready_i),
    .kill_i      (kill_i),
    .id_ex_o     (id_ex_o),
    .id_ready_o  (id_ready_o),
    .jmp_taken_o (jmp_taken_o)
  );

endmodule
